// File: design/trace_pkg.sv
/*
  shared widths, sync word and record layouts for the trace capture front end
  4-bit trace port only; the window holds the last 8 nibbles, newest in the low bits
  a set mask bit means that window bit takes part in the compare
  counters and the event delta saturate instead of wrapping
*/
package trace_pkg;

  localparam int TRACE_NIBBLE_BITS = 4;
  localparam int WINDOW_BITS       = 32;
  localparam int NUM_RULES         = 4;
  localparam int COUNT_BITS        = 8;   // hit counters, stop at 255
  localparam int DELTA_BITS        = 16;  // event timestamp, stops at 65535
  localparam int DELAY_BITS        = 16;
  localparam int WIDTH_BITS        = 8;

  // nibble 7 followed by seven nibbles of F
  localparam logic [WINDOW_BITS-1:0] SYNC_WORD = 32'h7fff_ffff;

  // one match rule
  typedef struct packed {
    logic                   enable;
    logic                   trig_en;  // rule may fire the trigger
    logic [WINDOW_BITS-1:0] pattern;
    logic [WINDOW_BITS-1:0] mask;
  } rule_cfg_t;

  typedef rule_cfg_t [NUM_RULES-1:0] rule_cfg_array_t;

  // trigger pulse settings
  typedef struct packed {
    logic [DELAY_BITS-1:0] delay;  // cycles before the pulse starts
    logic [WIDTH_BITS-1:0] width;  // pulse length, 0 disables
  } trig_cfg_t;

  // one match event
  typedef struct packed {
    logic [NUM_RULES-1:0]  rule_vec;
    logic [DELTA_BITS-1:0] delta;  // cycles since previous event
  } match_event_t;

  typedef logic [NUM_RULES-1:0][COUNT_BITS-1:0] rule_count_array_t;

endpackage

// File: design/trace_sync_decode.sv
/*
  nibble window and sync tracking for a 4-bit trace port
  synchronized is sticky, only reset clears it
  the window register itself carries no reset, it shifts on every edge
*/
`timescale 1ns/1ps

module trace_sync_decode import trace_pkg::*; (
  input  logic                         trace_clk,
  input  logic                         reset,
  input  logic [TRACE_NIBBLE_BITS-1:0] trace_data,
  output logic [WINDOW_BITS-1:0]       window,
  output logic                         window_valid,
  output logic                         synchronized
);

  logic sync_seen;  // window holds the sync word right now

  assign sync_seen = (window == SYNC_WORD);

  // newest nibble enters at the bottom, oldest drops off the top
  always_ff @(posedge trace_clk) begin
    window <= {window[WINDOW_BITS-TRACE_NIBBLE_BITS-1:0], trace_data};
  end

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      synchronized <= 1'b0;
    end else if (sync_seen) begin
      synchronized <= 1'b1;  // one cycle after the sync window
    end
  end

  // sync windows themselves are not trace content
  assign window_valid = synchronized && !sync_seen;

endmodule

// File: design/rule_matcher.sv
/*
  parallel masked compare of the trace window against all rules
  match_vec and match_valid are registered, one cycle after window_valid
  match_valid only rises when at least one enabled rule hits
  per-rule hit counters saturate at all ones
*/
`timescale 1ns/1ps

module rule_matcher import trace_pkg::*; (
  input  logic                   trace_clk,
  input  logic                   reset,
  input  logic [WINDOW_BITS-1:0] window,
  input  logic                   window_valid,
  input  rule_cfg_array_t        rule_cfg,
  output logic                   match_valid,
  output logic [NUM_RULES-1:0]   match_vec,
  output rule_count_array_t      rule_count
);

  logic [NUM_RULES-1:0] hit;

  // only masked bits take part in the compare
  always_comb begin
    for (int i = 0; i < NUM_RULES; i++) begin
      hit[i] = rule_cfg[i].enable &&
               ((window & rule_cfg[i].mask) == (rule_cfg[i].pattern & rule_cfg[i].mask));
    end
  end

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      match_valid <= 1'b0;
      match_vec   <= '0;
    end else begin
      match_valid <= window_valid && (|hit);
      match_vec   <= window_valid ? hit : '0;
    end
  end

  // counts move on the same edge that registers match_vec
  always_ff @(posedge trace_clk) begin
    if (reset) begin
      rule_count <= '0;
    end else begin
      for (int i = 0; i < NUM_RULES; i++) begin
        if (window_valid && hit[i] && !(&rule_count[i]))
          rule_count[i] <= rule_count[i] + 1'b1;  // stops at the cap
      end
    end
  end

endmodule

// File: design/trigger_pulse.sv
/*
  single delayed trigger pulse from matches on trigger-enabled rules
  the pulse starts delay+1 cycles after the edge that takes the match
  and lasts width cycles; width 0 never fires
  matches while delaying or pulsing are dropped, arm is sampled only when idle
*/
`timescale 1ns/1ps

module trigger_pulse import trace_pkg::*; (
  input  logic                 trace_clk,
  input  logic                 reset,
  input  logic                 arm,
  input  logic                 match_valid,
  input  logic [NUM_RULES-1:0] match_vec,
  input  rule_cfg_array_t      rule_cfg,
  input  trig_cfg_t            trig_cfg,
  output logic                 trig_out
);

  typedef enum logic [1:0] {IDLE, DELAYING, PULSING} state_t;

  state_t                state;
  logic [DELAY_BITS-1:0] cnt;         // shared by delay and width phases
  logic [NUM_RULES-1:0]  trig_rules;
  logic                  start;

  always_comb begin
    for (int i = 0; i < NUM_RULES; i++) begin
      trig_rules[i] = rule_cfg[i].trig_en;
    end
  end

  assign start = arm && match_valid && (|(match_vec & trig_rules)) &&
                 (trig_cfg.width != '0);

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      state    <= IDLE;
      cnt      <= '0;
      trig_out <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= DELAYING;
            cnt   <= trig_cfg.delay;
          end
        end
        DELAYING: begin
          if (cnt == '0) begin
            state    <= PULSING;
            trig_out <= 1'b1;
            cnt      <= DELAY_BITS'(trig_cfg.width - 1'b1);  // remaining high cycles
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        PULSING: begin
          if (cnt == '0) begin
            state    <= IDLE;
            trig_out <= 1'b0;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: design/match_event_record.sv
/*
  turns each match strobe into a timestamped event, one cycle later
  delta counts edges since the previous event, or since reset ended
  delta saturates at all ones; payload is only meaningful with event_valid
*/
`timescale 1ns/1ps

module match_event_record import trace_pkg::*; (
  input  logic                 trace_clk,
  input  logic                 reset,
  input  logic                 match_valid,
  input  logic [NUM_RULES-1:0] match_vec,
  output logic                 event_valid,
  output match_event_t         event_data
);

  logic [DELTA_BITS-1:0] gap_cnt;
  logic [DELTA_BITS-1:0] gap_next;

  assign gap_next = (&gap_cnt) ? gap_cnt : gap_cnt + 1'b1;  // saturating step

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      gap_cnt     <= '0;
      event_valid <= 1'b0;
    end else begin
      event_valid <= match_valid;
      gap_cnt     <= match_valid ? '0 : gap_next;  // restart on each event
    end
  end

  always_ff @(posedge trace_clk) begin
    if (match_valid) begin
      event_data.rule_vec <= match_vec;
      event_data.delta    <= gap_next;
    end
  end

endmodule

// File: design/trace_capture_top.sv
/*
  trace capture front end, everything on trace_clk
  configuration ports are expected to be static while capturing
  match_valid lands 2 cycles after the completing nibble, event_valid 3
*/
`timescale 1ns/1ps

module trace_capture_top import trace_pkg::*; (
  input  logic                         trace_clk,
  input  logic                         reset,
  input  logic [TRACE_NIBBLE_BITS-1:0] trace_data,
  input  logic                         arm,
  input  rule_cfg_array_t              rule_cfg,
  input  trig_cfg_t                    trig_cfg,
  output logic                         synchronized,
  output logic                         trig_out,
  output logic                         event_valid,
  output match_event_t                 event_data,
  output rule_count_array_t            rule_count
);

  logic [WINDOW_BITS-1:0] window;
  logic                   window_valid;
  logic                   match_valid;
  logic [NUM_RULES-1:0]   match_vec;

  trace_sync_decode u_sync_decode (
    .trace_clk    (trace_clk),
    .reset        (reset),
    .trace_data   (trace_data),
    .window       (window),
    .window_valid (window_valid),
    .synchronized (synchronized)
  );

  rule_matcher u_rule_matcher (
    .trace_clk    (trace_clk),
    .reset        (reset),
    .window       (window),
    .window_valid (window_valid),
    .rule_cfg     (rule_cfg),
    .match_valid  (match_valid),
    .match_vec    (match_vec),
    .rule_count   (rule_count)
  );

  trigger_pulse u_trigger_pulse (
    .trace_clk   (trace_clk),
    .reset       (reset),
    .arm         (arm),
    .match_valid (match_valid),
    .match_vec   (match_vec),
    .rule_cfg    (rule_cfg),
    .trig_cfg    (trig_cfg),
    .trig_out    (trig_out)
  );

  match_event_record u_event_record (
    .trace_clk   (trace_clk),
    .reset       (reset),
    .match_valid (match_valid),
    .match_vec   (match_vec),
    .event_valid (event_valid),
    .event_data  (event_data)
  );

endmodule

// File: dv/trace_capture_chk.sv
/*
  assertions bound into trace_capture_top that also watch the internal match strobe
  keeps its own nibble window, sync level and trigger timeline
  assumes rule and trigger configuration stay static after reset
  fail_cnt is read by the testbench for its closing summary
*/
`timescale 1ns/1ps

module trace_capture_chk import trace_pkg::*; (
  input logic                         trace_clk,
  input logic                         reset,
  input logic [TRACE_NIBBLE_BITS-1:0] trace_data,
  input logic                         arm,
  input rule_cfg_array_t              rule_cfg,
  input trig_cfg_t                    trig_cfg,
  input logic                         synchronized,
  input logic                         trig_out,
  input logic                         match_valid,
  input logic [NUM_RULES-1:0]         match_vec,
  input logic                         event_valid,
  input match_event_t                 event_data
);

  logic [WINDOW_BITS-1:0] win_q;      // same nibble history as the DUT sees
  logic                   sync_q;
  logic [NUM_RULES-1:0]   exp_hits;
  logic [NUM_RULES-1:0]   exp_vec_q;  // expected match_vec
  logic [NUM_RULES-1:0]   trig_set;
  logic                   trig_busy;
  logic [DELAY_BITS:0]    trig_age;   // edges since the trigger took a match
  logic [DELAY_BITS:0]    pulse_first;
  logic [DELAY_BITS:0]    pulse_last;
  logic                   exp_trig;
  logic [DELTA_BITS-1:0]  since_ev;   // edges since the previous event
  logic                   mv_q;       // match strobe one edge back
  logic [NUM_RULES-1:0]   mvec_q;
  int                     fail_cnt = 0;

  always_comb begin
    for (int i = 0; i < NUM_RULES; i++) begin
      exp_hits[i] = rule_cfg[i].enable &&
                    (((win_q ^ rule_cfg[i].pattern) & rule_cfg[i].mask) == '0);
      trig_set[i] = rule_cfg[i].trig_en;
    end
  end

  assign pulse_first = {1'b0, trig_cfg.delay} + 1'b1;
  assign pulse_last  = {1'b0, trig_cfg.delay} +
                       {{(DELAY_BITS-WIDTH_BITS+1){1'b0}}, trig_cfg.width};
  assign exp_trig    = trig_busy && (trig_age >= pulse_first) && (trig_age <= pulse_last);

  always_ff @(posedge trace_clk) begin
    win_q <= {win_q[WINDOW_BITS-TRACE_NIBBLE_BITS-1:0], trace_data};
    if (reset) begin
      sync_q    <= 1'b0;
      exp_vec_q <= '0;
      trig_busy <= 1'b0;
      trig_age  <= '0;
      since_ev  <= '0;
      mv_q      <= 1'b0;
      mvec_q    <= '0;
    end else begin
      if (win_q == SYNC_WORD)
        sync_q <= 1'b1;
      exp_vec_q <= (sync_q && win_q != SYNC_WORD) ? exp_hits : '0;
      if (!trig_busy) begin
        if (arm && match_valid && (match_vec & trig_set) != '0 && trig_cfg.width != '0) begin
          trig_busy <= 1'b1;
          trig_age  <= '0;
        end
      end else begin
        trig_age <= trig_age + 1'b1;
        if (trig_age == pulse_last)
          trig_busy <= 1'b0;  // free again one edge after the last high cycle
      end
      since_ev <= event_valid ? DELTA_BITS'(1) : ((&since_ev) ? since_ev : since_ev + 1'b1);
      mv_q     <= match_valid;
      mvec_q   <= match_vec;
    end
  end

  a_sync: assert property (@(posedge trace_clk) disable iff (reset) synchronized == sync_q)
    else begin
      fail_cnt++;
      $error("ERR sync: expected %b actual %b", $sampled(sync_q), $sampled(synchronized));
    end

  a_match: assert property (@(posedge trace_clk) disable iff (reset)
    match_valid == (exp_vec_q != '0) && (!match_valid || match_vec == exp_vec_q))
    else begin
      fail_cnt++;
      $error("ERR match: expected vec %b actual valid %b vec %b", $sampled(exp_vec_q),
             $sampled(match_valid), $sampled(match_vec));
    end

  a_trig: assert property (@(posedge trace_clk) disable iff (reset) trig_out == exp_trig)
    else begin
      fail_cnt++;
      $error("ERR trigger: expected %b actual %b", $sampled(exp_trig), $sampled(trig_out));
    end

  a_event: assert property (@(posedge trace_clk) disable iff (reset)
    event_valid == mv_q && (!event_valid || event_data.rule_vec == mvec_q))
    else begin
      fail_cnt++;
      $error("ERR event: expected valid %b vec %b actual valid %b vec %b", $sampled(mv_q),
             $sampled(mvec_q), $sampled(event_valid), $sampled(event_data.rule_vec));
    end

  a_delta: assert property (@(posedge trace_clk) disable iff (reset)
    event_valid |-> event_data.delta == since_ev)
    else begin
      fail_cnt++;
      $error("ERR delta: expected %0d actual %0d", $sampled(since_ev),
             $sampled(event_data.delta));
    end

endmodule

bind trace_capture_top trace_capture_chk chk_i (.*);

// File: dv/trace_capture_tb.sv
/*
  drives trace_capture_top with random and planted trace words
  value checks live in the bound assertions; here only the hit tally and stalls
  rule and trigger settings are set once before reset, only arm changes later
*/
`timescale 1ns/1ps

module trace_capture_tb import trace_pkg::*; ();

  localparam int WAIT_LIMIT = 64;  // cycles before a wait gives up

  logic                         trace_clk;
  logic                         reset;
  logic [TRACE_NIBBLE_BITS-1:0] trace_data;
  logic                         arm;
  rule_cfg_array_t              rule_cfg;
  trig_cfg_t                    trig_cfg;
  logic                         synchronized;
  logic                         trig_out;
  logic                         event_valid;
  match_event_t                 event_data;
  rule_count_array_t            rule_count;

  logic [WINDOW_BITS-1:0] model_win;  // last 8 nibbles driven
  logic                   model_sync;
  logic [COUNT_BITS-1:0]  tally [NUM_RULES];
  int                     count_errs;
  int                     timeout_errs;
  int                     seed;

  trace_capture_top dut_i (.*);

  initial begin
    trace_clk = 1'b0;
    forever #2 trace_clk = ~trace_clk;
  end

  // one nibble per edge, tallying every trace window it completes
  task automatic send_nibble(input logic [TRACE_NIBBLE_BITS-1:0] nib);
    @(posedge trace_clk);
    trace_data <= nib;
    model_win = {model_win[WINDOW_BITS-TRACE_NIBBLE_BITS-1:0], nib};
    if (model_sync && model_win != SYNC_WORD) begin
      for (int i = 0; i < NUM_RULES; i++) begin
        if (rule_cfg[i].enable && !(&tally[i]) &&
            (model_win & rule_cfg[i].mask) == (rule_cfg[i].pattern & rule_cfg[i].mask))
          tally[i] = tally[i] + 1'b1;
      end
    end
    if (model_win == SYNC_WORD)
      model_sync = 1'b1;  // windows after this one count
  endtask

  task automatic send_word(input logic [WINDOW_BITS-1:0] word);
    for (int k = WINDOW_BITS / TRACE_NIBBLE_BITS - 1; k >= 0; k--)
      send_nibble(word[k*TRACE_NIBBLE_BITS +: TRACE_NIBBLE_BITS]);
  endtask

  task automatic send_random(input int n);
    int rnd;
    repeat (n) begin
      rnd = $random(seed);
      send_nibble(rnd[TRACE_NIBBLE_BITS-1:0]);
    end
  endtask

  // idle nibbles until the named output reaches level
  task automatic wait_output(input string what, input logic level);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
      send_nibble(4'h0);
      @(negedge trace_clk);
      if (what == "synchronized")
        seen = (synchronized == level);
      else if (what == "trig_out")
        seen = (trig_out == level);
      else
        seen = (event_valid == level);
      n++;
    end
    if (!seen) begin
      timeout_errs++;
      $display("timeout: %s did not reach %b within %0d cycles", what, level, WAIT_LIMIT);
    end
  endtask

  initial begin
    seed         = 41904;
    count_errs   = 0;
    timeout_errs = 0;
    model_win    = '0;
    model_sync   = 1'b0;
    foreach (tally[i])
      tally[i] = '0;
    reset       <= 1'b1;
    trace_data  <= '0;
    arm         <= 1'b0;
    rule_cfg[0] <= '{enable: 1'b1, trig_en: 1'b1, pattern: 32'h1234_5678, mask: '1};
    rule_cfg[1] <= '{enable: 1'b1, trig_en: 1'b1, pattern: 32'hdead_0000, mask: 32'hffff_0000};
    rule_cfg[2] <= '{enable: 1'b1, trig_en: 1'b0, pattern: 32'h3, mask: 32'hf};  // newest nibble
    rule_cfg[3] <= '{enable: 1'b0, trig_en: 1'b1, pattern: '0, mask: '0};  // would hit all
    trig_cfg    <= '{delay: 16'd5, width: 8'd3};
    repeat (16) send_nibble(4'h0);
    reset <= 1'b0;

    send_random(40);
    send_word(32'h1234_5678);  // not synchronized yet, must not match
    send_word(SYNC_WORD);
    wait_output("synchronized", 1'b1);

    repeat (12) begin
      send_random(20);
      send_word(32'h1234_5678);
      send_random(5);
      send_word(32'hdead_beef);
      send_nibble(4'h3);
    end
    repeat (300) send_nibble(4'h3);  // rule 2 past its counter cap

    send_nibble(4'h0);
    arm <= 1'b1;
    send_word(32'h1234_5678);
    send_word(32'hdead_0000);  // lands inside the first pulse
    wait_output("trig_out", 1'b1);
    wait_output("trig_out", 1'b0);
    send_nibble(4'h0);
    arm <= 1'b0;
    send_word(32'h1234_5678);
    repeat (20) send_nibble(4'h0);
    arm <= 1'b1;
    repeat (4) send_nibble(4'h3);  // no trigger rule among these
    repeat (20) send_nibble(4'h0);

    repeat (70000) send_nibble(4'h0);  // quiet gap, longer than the delta range
    send_word(32'h1234_5678);
    wait_output("event_valid", 1'b1);
    send_word(32'hdead_0000);
    wait_output("event_valid", 1'b1);
    repeat (8) send_nibble(4'h0);
    @(negedge trace_clk);

    for (int i = 0; i < NUM_RULES; i++) begin
      if (rule_count[i] !== tally[i]) begin
        count_errs++;
        $display("ERR hit_count rule %0d: expected %0d actual %0d", i, tally[i], rule_count[i]);
      end
    end
    $display("errors: %0d count, %0d timeout, %0d assertion", count_errs, timeout_errs,
             dut_i.chk_i.fail_cnt);
    if (count_errs + timeout_errs + dut_i.chk_i.fail_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: tb.f
design/trace_pkg.sv
design/trace_sync_decode.sv
design/rule_matcher.sv
design/trigger_pulse.sv
design/match_event_record.sv
design/trace_capture_top.sv
dv/trace_capture_chk.sv
dv/trace_capture_tb.sv

// File: Makefile
# Verilator build and run of the trace capture testbench
TOP := trace_capture_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
